/* logic/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W      = 16;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int SHAMT_W    = 5;

	// Opcodes --------------------
	localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'b000000;
	localparam logic [OPCODE_W-1:0] OP_LW    = 6'b100011;
	localparam logic [OPCODE_W-1:0] OP_SW    = 6'b101011;
	localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'b001000;
	localparam logic [OPCODE_W-1:0] OP_ADDIU = 6'b001001;
	localparam logic [OPCODE_W-1:0] OP_ORI   = 6'b001101;
	localparam logic [OPCODE_W-1:0] OP_SLTI  = 6'b001010;
	localparam logic [OPCODE_W-1:0] OP_SLTIU = 6'b001011;
	localparam logic [OPCODE_W-1:0] OP_LUI   = 6'b001111;

	// R-type funct codes --------------------
	localparam logic [FUNCT_W-1:0] FN_ADD  = 6'b100000;
	localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;
	localparam logic [FUNCT_W-1:0] FN_SUB  = 6'b100010;
	localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;
	localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
	localparam logic [FUNCT_W-1:0] FN_OR   = 6'b100101;
	localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;
	localparam logic [FUNCT_W-1:0] FN_SLTU = 6'b101011;

	typedef struct packed {
		logic [OPCODE_W-1:0]   opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [SHAMT_W-1:0]    shamt;
		logic [FUNCT_W-1:0]    funct;
	} r_fields_t;

	typedef struct packed {
		logic [OPCODE_W-1:0]   opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [IMM_W-1:0]      imm;
	} i_fields_t;

	// One instruction word, two field layouts
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_u;

endpackage

`default_nettype wire

/* logic/mips_pipe_pkg.sv */
`default_nettype none

package mips_pipe_pkg;

	localparam int ALU_CTRL_W  = 4;
	localparam int ALU_SUB_BIT = 2; // Invert b, carry in 1
	localparam int ALU_UNS_BIT = 3; // Compare uses carry, not N xor V

	// ALU control codes --------------------
	localparam logic [ALU_CTRL_W-1:0] ALU_AND  = 4'b0000;
	localparam logic [ALU_CTRL_W-1:0] ALU_OR   = 4'b0001;
	localparam logic [ALU_CTRL_W-1:0] ALU_ADD  = 4'b0010;
	localparam logic [ALU_CTRL_W-1:0] ALU_SUB  = 4'b0110;
	localparam logic [ALU_CTRL_W-1:0] ALU_SLT  = 4'b0111;
	localparam logic [ALU_CTRL_W-1:0] ALU_SLTU = 4'b1111;

	// Operand sources in execute --------------------
	localparam int FWD_W = 2;

	localparam logic [FWD_W-1:0] FWD_REG = 2'b00;
	localparam logic [FWD_W-1:0] FWD_MEM = 2'b01;
	localparam logic [FWD_W-1:0] FWD_WB  = 2'b10;

	localparam logic [mips_isa_pkg::REG_ADDR_W-1:0] REG_ZERO = '0;

	localparam logic [mips_isa_pkg::XLEN-1:0] PC_STEP = 4;

endpackage

`default_nettype wire

/* logic/ex_mem_if.sv */
`default_nettype none

interface ex_mem_if;

	logic [mips_isa_pkg::XLEN-1:0]       aluout;
	logic [mips_isa_pkg::XLEN-1:0]       write_data; // Store data after forwarding
	logic [mips_isa_pkg::REG_ADDR_W-1:0] writereg;
	logic                                regwrite;
	logic                                memtoreg;
	logic                                memwrite;

	modport stage (
		output aluout, write_data, writereg,
		output regwrite, memtoreg, memwrite
	);

	modport sink (
		input aluout, write_data, writereg,
		input regwrite, memtoreg, memwrite
	);

endinterface

`default_nettype wire

/* logic/front_end.sv */
`default_nettype none

module front_end (
	input  wire logic                                  clk,
	input  wire logic                                  reset,
	input  wire logic [mips_isa_pkg::XLEN-1:0]         imem_instr,
	input  wire logic                                  wb_regwrite,
	input  wire logic [mips_isa_pkg::REG_ADDR_W-1:0]   wb_reg,
	input  wire logic [mips_isa_pkg::XLEN-1:0]         wb_result,
	output logic      [mips_isa_pkg::XLEN-1:0]         imem_addr,
	output logic      [mips_isa_pkg::REG_ADDR_W-1:0]   ex_rs,
	output logic      [mips_isa_pkg::REG_ADDR_W-1:0]   ex_rt,
	output logic      [mips_isa_pkg::REG_ADDR_W-1:0]   ex_rd,
	output logic      [mips_isa_pkg::XLEN-1:0]         ex_rd1,
	output logic      [mips_isa_pkg::XLEN-1:0]         ex_rd2,
	output logic      [mips_isa_pkg::XLEN-1:0]         ex_imm,
	output logic                                       ex_regdst,
	output logic                                       ex_alusrc,
	output logic                                       ex_regwrite,
	output logic                                       ex_memtoreg,
	output logic                                       ex_memwrite,
	output logic      [mips_pipe_pkg::ALU_CTRL_W-1:0]  ex_alucontrol
);

	localparam int XLEN  = mips_isa_pkg::XLEN;
	localparam int IMM_W = mips_isa_pkg::IMM_W;

	logic [XLEN-1:0]                      pc;
	mips_isa_pkg::instr_u                 id_instr;
	logic [XLEN-1:0]                      rf [1:31]; // No storage for register 0
	logic [XLEN-1:0]                      id_rd1, id_rd2, id_imm;
	logic                                 id_regwrite, id_regdst, id_alusrc;
	logic                                 id_memtoreg, id_memwrite;
	logic                                 id_signext, id_shiftl16;
	logic [mips_pipe_pkg::ALU_CTRL_W-1:0] id_alucontrol;
	logic                                 load_use;

	// Fetch --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc       <= '0;
			id_instr <= '0;
		end else if (!load_use) begin
			pc       <= pc + mips_pipe_pkg::PC_STEP;
			id_instr <= imem_instr;
		end
	end

	assign imem_addr = pc;

	// Register file --------------------
	always_ff @(posedge clk) begin
		if (wb_regwrite && wb_reg != mips_pipe_pkg::REG_ZERO)
			rf[wb_reg] <= wb_result;
	end

	// Same-cycle writeback is seen by the reader
	function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
		if (addr == mips_pipe_pkg::REG_ZERO)
			return '0;
		else if (wb_regwrite && wb_reg == addr)
			return wb_result;
		else
			return rf[addr];
	endfunction

	assign id_rd1 = read_port(id_instr.i.rs);
	assign id_rd2 = read_port(id_instr.i.rt);

	// Decode --------------------
	always_comb begin
		id_regwrite   = 1'b0;
		id_regdst     = 1'b0;
		id_alusrc     = 1'b0;
		id_memtoreg   = 1'b0;
		id_memwrite   = 1'b0;
		id_signext    = 1'b0;
		id_shiftl16   = 1'b0;
		id_alucontrol = mips_pipe_pkg::ALU_AND;
		case (id_instr.i.opcode)
			mips_isa_pkg::OP_RTYPE: begin
				id_regwrite = 1'b1;
				id_regdst   = 1'b1;
				case (id_instr.r.funct)
					mips_isa_pkg::FN_ADD,
					mips_isa_pkg::FN_ADDU: id_alucontrol = mips_pipe_pkg::ALU_ADD;
					mips_isa_pkg::FN_SUB,
					mips_isa_pkg::FN_SUBU: id_alucontrol = mips_pipe_pkg::ALU_SUB;
					mips_isa_pkg::FN_AND:  id_alucontrol = mips_pipe_pkg::ALU_AND;
					mips_isa_pkg::FN_OR:   id_alucontrol = mips_pipe_pkg::ALU_OR;
					mips_isa_pkg::FN_SLT:  id_alucontrol = mips_pipe_pkg::ALU_SLT;
					mips_isa_pkg::FN_SLTU: id_alucontrol = mips_pipe_pkg::ALU_SLTU;
					default:               id_regwrite   = 1'b0; // Shifts etc. not kept
				endcase
			end
			mips_isa_pkg::OP_LW: begin
				id_regwrite   = 1'b1;
				id_alusrc     = 1'b1;
				id_memtoreg   = 1'b1;
				id_signext    = 1'b1;
				id_alucontrol = mips_pipe_pkg::ALU_ADD;
			end
			mips_isa_pkg::OP_SW: begin
				id_alusrc     = 1'b1;
				id_memwrite   = 1'b1;
				id_signext    = 1'b1;
				id_alucontrol = mips_pipe_pkg::ALU_ADD;
			end
			mips_isa_pkg::OP_ADDI,
			mips_isa_pkg::OP_ADDIU: begin
				id_regwrite   = 1'b1;
				id_alusrc     = 1'b1;
				id_signext    = 1'b1;
				id_alucontrol = mips_pipe_pkg::ALU_ADD;
			end
			mips_isa_pkg::OP_ORI: begin
				id_regwrite   = 1'b1;
				id_alusrc     = 1'b1;
				id_alucontrol = mips_pipe_pkg::ALU_OR;
			end
			mips_isa_pkg::OP_SLTI,
			mips_isa_pkg::OP_SLTIU: begin
				id_regwrite   = 1'b1;
				id_alusrc     = 1'b1;
				id_signext    = 1'b1; // SLTIU still sign-extends
				id_alucontrol = (id_instr.i.opcode == mips_isa_pkg::OP_SLTI) ?
					mips_pipe_pkg::ALU_SLT : mips_pipe_pkg::ALU_SLTU;
			end
			mips_isa_pkg::OP_LUI: begin
				id_regwrite   = 1'b1;
				id_alusrc     = 1'b1;
				id_shiftl16   = 1'b1;
				id_alucontrol = mips_pipe_pkg::ALU_ADD; // rs field is zero
			end
			default: ;
		endcase
	end

	always_comb begin
		if (id_shiftl16)
			id_imm = {id_instr.i.imm, {(XLEN-IMM_W){1'b0}}};
		else if (id_signext)
			id_imm = {{(XLEN-IMM_W){id_instr.i.imm[IMM_W-1]}}, id_instr.i.imm};
		else
			id_imm = {{(XLEN-IMM_W){1'b0}}, id_instr.i.imm};
	end

	// Loads write rt
	assign load_use = ex_memtoreg && (ex_rt != mips_pipe_pkg::REG_ZERO) &&
		(ex_rt == id_instr.i.rs || ex_rt == id_instr.i.rt);

	// ID/EX --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ex_regdst     <= 1'b0;
			ex_alusrc     <= 1'b0;
			ex_regwrite   <= 1'b0;
			ex_memtoreg   <= 1'b0;
			ex_memwrite   <= 1'b0;
			ex_alucontrol <= '0;
		end else if (load_use) begin // Bubble
			ex_regdst     <= 1'b0;
			ex_alusrc     <= 1'b0;
			ex_regwrite   <= 1'b0;
			ex_memtoreg   <= 1'b0;
			ex_memwrite   <= 1'b0;
			ex_alucontrol <= '0;
		end else begin
			ex_regdst     <= id_regdst;
			ex_alusrc     <= id_alusrc;
			ex_regwrite   <= id_regwrite;
			ex_memtoreg   <= id_memtoreg;
			ex_memwrite   <= id_memwrite;
			ex_alucontrol <= id_alucontrol;
		end
	end

	always_ff @(posedge clk) begin
		ex_rs  <= id_instr.i.rs;
		ex_rt  <= id_instr.i.rt;
		ex_rd  <= id_instr.r.rd;
		ex_rd1 <= id_rd1;
		ex_rd2 <= id_rd2;
		ex_imm <= id_imm;
	end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none

module execute_stage (
	input  wire logic                                  clk,
	input  wire logic                                  reset,
	input  wire logic [mips_isa_pkg::REG_ADDR_W-1:0]   ex_rs,
	input  wire logic [mips_isa_pkg::REG_ADDR_W-1:0]   ex_rt,
	input  wire logic [mips_isa_pkg::REG_ADDR_W-1:0]   ex_rd,
	input  wire logic [mips_isa_pkg::XLEN-1:0]         ex_rd1,
	input  wire logic [mips_isa_pkg::XLEN-1:0]         ex_rd2,
	input  wire logic [mips_isa_pkg::XLEN-1:0]         ex_imm,
	input  wire logic                                  ex_regdst,
	input  wire logic                                  ex_alusrc,
	input  wire logic                                  ex_regwrite,
	input  wire logic                                  ex_memtoreg,
	input  wire logic                                  ex_memwrite,
	input  wire logic [mips_pipe_pkg::ALU_CTRL_W-1:0]  ex_alucontrol,
	input  wire logic                                  wb_regwrite,
	input  wire logic [mips_isa_pkg::REG_ADDR_W-1:0]   wb_reg,
	input  wire logic [mips_isa_pkg::XLEN-1:0]         wb_result,
	ex_mem_if.stage                                    em
);

	localparam int XLEN = mips_isa_pkg::XLEN;

	logic [mips_pipe_pkg::FWD_W-1:0]     sel_a, sel_b;
	logic [XLEN-1:0]                     alu_a, store_val, alu_b, b_add;
	logic [XLEN:0]                       add_full;
	logic [XLEN-1:0]                     sum, alu_result;
	logic                                carry, overflow, lt_signed, lt_unsigned;
	logic [mips_isa_pkg::REG_ADDR_W-1:0] writereg;

	// Forwarding --------------------
	// Nearest producer wins, register 0 never forwarded
	function automatic logic [1:0] fwd_sel(
		input logic [4:0] src,
		input logic       mem_we,
		input logic [4:0] mem_reg,
		input logic       wb_we,
		input logic [4:0] wb_dst
	);
		if (mem_we && mem_reg != mips_pipe_pkg::REG_ZERO && mem_reg == src)
			return mips_pipe_pkg::FWD_MEM;
		else if (wb_we && wb_dst != mips_pipe_pkg::REG_ZERO && wb_dst == src)
			return mips_pipe_pkg::FWD_WB;
		else
			return mips_pipe_pkg::FWD_REG;
	endfunction

	assign sel_a = fwd_sel(ex_rs, em.regwrite, em.writereg, wb_regwrite, wb_reg);
	assign sel_b = fwd_sel(ex_rt, em.regwrite, em.writereg, wb_regwrite, wb_reg);

	always_comb begin
		case (sel_a)
			mips_pipe_pkg::FWD_MEM: alu_a = em.aluout;
			mips_pipe_pkg::FWD_WB:  alu_a = wb_result;
			default:                alu_a = ex_rd1;
		endcase
		case (sel_b)
			mips_pipe_pkg::FWD_MEM: store_val = em.aluout;
			mips_pipe_pkg::FWD_WB:  store_val = wb_result;
			default:                store_val = ex_rd2;
		endcase
	end

	assign alu_b = ex_alusrc ? ex_imm : store_val;

	// ALU --------------------
	assign b_add    = ex_alucontrol[mips_pipe_pkg::ALU_SUB_BIT] ? ~alu_b : alu_b;
	assign add_full = {1'b0, alu_a} + {1'b0, b_add} +
		{{XLEN{1'b0}}, ex_alucontrol[mips_pipe_pkg::ALU_SUB_BIT]};
	assign sum      = add_full[XLEN-1:0];
	assign carry    = add_full[XLEN];
	assign overflow = (alu_a[XLEN-1] == b_add[XLEN-1]) && (sum[XLEN-1] != alu_a[XLEN-1]);

	assign lt_signed   = sum[XLEN-1] ^ overflow;
	assign lt_unsigned = ~carry; // Borrow out of a - b

	always_comb begin
		case (ex_alucontrol[1:0])
			2'b00:   alu_result = alu_a & alu_b;
			2'b01:   alu_result = alu_a | alu_b;
			2'b10:   alu_result = sum;
			default: alu_result = {{(XLEN-1){1'b0}},
				ex_alucontrol[mips_pipe_pkg::ALU_UNS_BIT] ? lt_unsigned : lt_signed};
		endcase
	end

	assign writereg = ex_regdst ? ex_rd : ex_rt;

	// EX/MEM --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			em.regwrite <= 1'b0;
			em.memtoreg <= 1'b0;
			em.memwrite <= 1'b0;
		end else begin
			em.regwrite <= ex_regwrite;
			em.memtoreg <= ex_memtoreg;
			em.memwrite <= ex_memwrite;
		end
	end

	always_ff @(posedge clk) begin
		em.aluout     <= alu_result;
		em.write_data <= store_val;
		em.writereg   <= writereg;
	end

endmodule

`default_nettype wire

/* logic/memory_writeback.sv */
`default_nettype none

module memory_writeback (
	input  wire logic                                clk,
	input  wire logic                                reset,
	ex_mem_if.sink                                   em,
	input  wire logic [mips_isa_pkg::XLEN-1:0]       dmem_rdata,
	output logic                                     wb_regwrite,
	output logic      [mips_isa_pkg::REG_ADDR_W-1:0] wb_reg,
	output logic      [mips_isa_pkg::XLEN-1:0]       wb_result
);

	logic                          wb_memtoreg;
	logic [mips_isa_pkg::XLEN-1:0] wb_aluout;
	logic [mips_isa_pkg::XLEN-1:0] wb_rdata;

	// MEM/WB --------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wb_regwrite <= 1'b0;
			wb_memtoreg <= 1'b0;
		end else begin
			wb_regwrite <= em.regwrite;
			wb_memtoreg <= em.memtoreg;
		end
	end

	always_ff @(posedge clk) begin
		wb_reg    <= em.writereg;
		wb_aluout <= em.aluout;
		wb_rdata  <= dmem_rdata; // Read data valid in the memory cycle
	end

	assign wb_result = wb_memtoreg ? wb_rdata : wb_aluout;

endmodule

`default_nettype wire

/* logic/mips_pipeline.sv */
`default_nettype none

module mips_pipeline (
	input  wire logic                          clk,
	input  wire logic                          reset,
	output logic      [mips_isa_pkg::XLEN-1:0] imem_addr,
	input  wire logic [mips_isa_pkg::XLEN-1:0] imem_instr,
	output logic      [mips_isa_pkg::XLEN-1:0] dmem_addr,
	output logic      [mips_isa_pkg::XLEN-1:0] dmem_wdata,
	output logic                               dmem_we,
	input  wire logic [mips_isa_pkg::XLEN-1:0] dmem_rdata
);

	logic [mips_isa_pkg::REG_ADDR_W-1:0]  ex_rs, ex_rt, ex_rd;
	logic [mips_isa_pkg::XLEN-1:0]        ex_rd1, ex_rd2, ex_imm;
	logic                                 ex_regdst, ex_alusrc, ex_regwrite;
	logic                                 ex_memtoreg, ex_memwrite;
	logic [mips_pipe_pkg::ALU_CTRL_W-1:0] ex_alucontrol;
	logic                                 wb_regwrite;
	logic [mips_isa_pkg::REG_ADDR_W-1:0]  wb_reg;
	logic [mips_isa_pkg::XLEN-1:0]        wb_result;

	ex_mem_if em ();

	front_end i_front_end (
		.clk, .reset, .imem_instr, .wb_regwrite, .wb_reg, .wb_result, .imem_addr,
		.ex_rs, .ex_rt, .ex_rd, .ex_rd1, .ex_rd2, .ex_imm,
		.ex_regdst, .ex_alusrc, .ex_regwrite, .ex_memtoreg, .ex_memwrite, .ex_alucontrol
	);

	execute_stage i_execute_stage (
		.clk, .reset,
		.ex_rs, .ex_rt, .ex_rd, .ex_rd1, .ex_rd2, .ex_imm,
		.ex_regdst, .ex_alusrc, .ex_regwrite, .ex_memtoreg, .ex_memwrite, .ex_alucontrol,
		.wb_regwrite, .wb_reg, .wb_result,
		.em (em)
	);

	memory_writeback i_memory_writeback (
		.clk, .reset,
		.em (em),
		.dmem_rdata, .wb_regwrite, .wb_reg, .wb_result
	);

	// Data memory driven straight from EX/MEM
	assign dmem_addr  = em.aluout;
	assign dmem_wdata = em.write_data;
	assign dmem_we    = em.memwrite;

endmodule

`default_nettype wire

/* test/mips_pipeline_assertions.sv */
`default_nettype none

module mips_pipeline_assertions (
	input wire logic                          clk,
	input wire logic                          reset,
	input wire logic [mips_isa_pkg::XLEN-1:0] imem_addr,
	input wire logic [mips_isa_pkg::XLEN-1:0] dmem_addr,
	input wire logic                          dmem_we
);

	int violations = 0; // Failure count

	we_low_in_reset: assert property (@(posedge clk) reset |-> !dmem_we)
		else begin
			violations = violations + 1;
			$error("dmem_we high while reset is asserted");
		end

	// Fetch only steps forward or stalls
	pc_step_or_hold: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> (imem_addr == $past(imem_addr) ||
			imem_addr == $past(imem_addr) + mips_pipe_pkg::PC_STEP))
		else begin
			violations = violations + 1;
			$error("imem_addr neither held nor advanced by one word");
		end

	store_aligned: assert property (@(posedge clk) dmem_we |-> dmem_addr[1:0] == 2'b00)
		else begin
			violations = violations + 1;
			$error("Store address %h not word aligned", dmem_addr);
		end

endmodule

bind mips_pipeline mips_pipeline_assertions i_mips_pipeline_assertions (
	.clk, .reset, .imem_addr, .dmem_addr, .dmem_we
);

`default_nettype wire

/* test/mips_pipeline_tb.sv */
`default_nettype none

module mips_pipeline_tb;

	logic                          clk = 1'b0;
	logic                          reset;
	logic [mips_isa_pkg::XLEN-1:0] imem_addr;
	logic [mips_isa_pkg::XLEN-1:0] imem_instr;
	logic [mips_isa_pkg::XLEN-1:0] dmem_addr;
	logic [mips_isa_pkg::XLEN-1:0] dmem_wdata;
	logic [mips_isa_pkg::XLEN-1:0] dmem_rdata;
	logic                          dmem_we;

	logic [mips_isa_pkg::XLEN-1:0] imem [0:255];
	logic [mips_isa_pkg::XLEN-1:0] dmem [0:255];
	logic [mips_isa_pkg::XLEN-1:0] exp_addr [$]; // Expected stores in program order
	logic [mips_isa_pkg::XLEN-1:0] exp_data [$];
	int                            prog_words = 0;
	int                            stores_seen = 0;
	int                            cycles = 0;
	int                            cycle_limit = 0;

	mips_pipeline i_mips_pipeline (
		.clk, .reset, .imem_addr, .imem_instr,
		.dmem_addr, .dmem_wdata, .dmem_we, .dmem_rdata
	);

	always #4 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_value(
		input string                         name,
		input logic [mips_isa_pkg::XLEN-1:0] expected,
		input logic [mips_isa_pkg::XLEN-1:0] actual
	);
		if (actual !== expected)
			abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic load_trace();
		int                            fd;
		int                            code;
		string                         line;
		logic [7:0]                    tag;
		logic [mips_isa_pkg::XLEN-1:0] addr;
		logic [mips_isa_pkg::XLEN-1:0] word;
		fd = $fopen("test/mips_trace.txt", "r");
		if (fd == 0) begin
			abort_run("Cannot open the trace file test/mips_trace.txt");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 1 && line.getc(0) != "#") begin
					code = $sscanf(line, "%c %h %h", tag, addr, word);
					if (code != 3 || addr[1:0] != 2'b00 || addr[31:10] != '0) begin
						abort_run($sformatf("Malformed trace line: %s", line));
					end else begin
						case (tag)
							"P": begin
								imem[addr[9:2]] = word;
								prog_words++;
							end
							"D": dmem[addr[9:2]] = word;
							"S": begin
								exp_addr.push_back(addr);
								exp_data.push_back(word);
							end
							default: abort_run($sformatf("Unknown trace tag in line: %s", line));
						endcase
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Memories --------------------
	assign imem_instr = (imem_addr[31:10] == '0) ? imem[imem_addr[9:2]] : '0; // Nop past the array
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (dmem_we)
			dmem[dmem_addr[9:2]] <= dmem_wdata;
	end

	// Store checking --------------------
	always @(negedge clk) begin : store_check
		logic [mips_isa_pkg::XLEN-1:0] want_addr;
		logic [mips_isa_pkg::XLEN-1:0] want_data;
		if (!reset && dmem_we) begin
			if (exp_addr.size() == 0) begin
				abort_run($sformatf("Store to %h with data %h after the last expected store",
					dmem_addr, dmem_wdata));
			end else begin
				want_addr = exp_addr.pop_front();
				want_data = exp_data.pop_front();
				check_value($sformatf("store %0d address", stores_seen), want_addr, dmem_addr);
				check_value($sformatf("store %0d data", stores_seen), want_data, dmem_wdata);
				stores_seen++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit)
			abort_run($sformatf("Timeout after %0d cycles with %0d stores still outstanding",
				cycles, exp_addr.size()));
	end

	// Main sequence --------------------
	initial begin
		reset = 1'b1;
		for (int i = 0; i < $size(imem); i++) begin
			imem[i[7:0]] = '0;
			dmem[i[7:0]] = 32'hC0DE_0000 | 32'(i << 2); // Byte address in the low half
		end
		load_trace();
		cycle_limit = 2 * prog_words + 40;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		while (exp_addr.size() != 0)
			@(posedge clk);
		repeat (10) @(posedge clk); // No store allowed in the quiet tail
		if (i_mips_pipeline.i_mips_pipeline_assertions.violations == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			abort_run($sformatf("Port rule assertions failed %0d times",
				i_mips_pipeline.i_mips_pipeline_assertions.violations));
		end
	end

endmodule

`default_nettype wire

/* test/mips_trace.txt */
# Columns: tag address word, hex. P program word, D initial data word, S expected store.
# S records are matched in order against the DUT stores. Text after the word is ignored.
D 00000040 80000010  load source
D 00000044 00000007  load source
P 00000000 2001fffb  addi  $1, $0, -5
P 00000004 34028001  ori   $2, $0, 0x8001
P 00000008 3c038000  lui   $3, 0x8000
P 0000000c 00222020  add   $4, $1, $2
P 00000010 ac040000  sw    $4, 0($0)
P 00000014 00412822  sub   $5, $2, $1
P 00000018 00a23024  and   $6, $5, $2
P 0000001c 00c53825  or    $7, $6, $5
P 00000020 ac050004  sw    $5, 4($0)
P 00000024 ac060008  sw    $6, 8($0)
P 00000028 ac07000c  sw    $7, 12($0)
P 0000002c 0062402a  slt   $8, $3, $2
P 00000030 0062482b  sltu  $9, $3, $2
P 00000034 282a0001  slti  $10, $1, 1
P 00000038 2c2b0001  sltiu $11, $1, 1
P 0000003c ac080010  sw    $8, 16($0)
P 00000040 ac090014  sw    $9, 20($0)
P 00000044 ac0a0018  sw    $10, 24($0)
P 00000048 ac0b001c  sw    $11, 28($0)
P 0000004c 8c0c0040  lw    $12, 0x40($0)
P 00000050 01816821  addu  $13, $12, $1
P 00000054 ac0d0020  sw    $13, 32($0)
P 00000058 8c0e0044  lw    $14, 0x44($0)
P 0000005c ac0e0024  sw    $14, 36($0)
P 00000060 24400055  addiu $0, $2, 0x55
P 00000064 ac000028  sw    $0, 40($0)
P 00000068 ac03002c  sw    $3, 44($0)
S 00000000 00007ffc  add
S 00000004 00008006  sub
S 00000008 00008000  and
S 0000000c 00008006  or
S 00000010 00000001  slt
S 00000014 00000000  sltu
S 00000018 00000001  slti
S 0000001c 00000000  sltiu
S 00000020 8000000b  load then addu
S 00000024 00000007  load then store
S 00000028 00000000  register 0
S 0000002c 80000000  lui

/* mips_pipeline.f */
logic/mips_isa_pkg.sv
logic/mips_pipe_pkg.sv
logic/ex_mem_if.sv
logic/front_end.sv
logic/execute_stage.sv
logic/memory_writeback.sv
logic/mips_pipeline.sv
test/mips_pipeline_assertions.sv
test/mips_pipeline_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mips_pipeline_tb
FILELIST  ?= mips_pipeline.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
